// File: rtl/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

`define EXU_XLEN       32 // data word.
`define EXU_SHAMT_W    5  // shift amount, log2 of the word.
`define EXU_REG_IDX_W  5  // destination register index.
`define EXU_CSR_WEN_W  4  // csr write mask.
`define EXU_FUNCT3_W   3  // access size and compare code.

`endif

// File: rtl/exu_op_pkg.sv
`include "exu_defines.svh"

package exu_op_pkg;

    typedef logic [`EXU_XLEN-1:0]      word_t;
    typedef logic [`EXU_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EXU_CSR_WEN_W-1:0] csr_wen_t;
    typedef logic [`EXU_FUNCT3_W-1:0]  funct3_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_eq     = 4'd10,
        alu_pass_b = 4'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i12 = 3'd0, // sign-extended 12 bit.
        imm_u20 = 3'd1, // upper, shifted by 12.
        imm_j20 = 3'd2, // jal offset.
        imm_b12 = 3'd3, // branch offset.
        imm_u5  = 3'd4  // csr zimm.
    } imm_kind_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_pc   = 2'd1,
        opa_zero = 2'd2
    } opa_sel_e;

    typedef enum logic [1:0] {
        opb_imm  = 2'd0,
        opb_rs2  = 2'd1,
        opb_csr  = 2'd2,
        opb_four = 2'd3 // link value for jumps.
    } opb_sel_e;

endpackage

// File: rtl/exu_bus_pkg.sv
package exu_bus_pkg;

    typedef struct packed {
        exu_op_pkg::word_t     pc;
        exu_op_pkg::word_t     rs1;
        exu_op_pkg::word_t     rs2;
        exu_op_pkg::word_t     csr;
        exu_op_pkg::word_t     imm;      // raw field, formed in the stage.
        exu_op_pkg::imm_kind_e imm_kind;
        exu_op_pkg::alu_op_e   alu_op;
        logic                  invert;   // flips bit 0 for bge, bgeu, bne.
        exu_op_pkg::opa_sel_e  opa_sel;
        exu_op_pkg::opb_sel_e  opb_sel;
        logic                  branch;
        logic                  jump;
        logic                  jump_reg;
        exu_op_pkg::funct3_t   funct3;
        exu_op_pkg::reg_idx_t  rd;
        logic                  reg_wen;
        logic                  mem_ren;
        logic                  mem_wen;
        exu_op_pkg::csr_wen_t  csr_wen;
    } issue_t;

    typedef struct packed {
        exu_op_pkg::word_t    pc;
        exu_op_pkg::word_t    rs1;
        exu_op_pkg::word_t    rs2;      // store data.
        exu_op_pkg::word_t    csr;
        exu_op_pkg::word_t    imm;      // formed immediate.
        exu_op_pkg::word_t    alu;      // after inversion.
        exu_op_pkg::funct3_t  funct3;
        exu_op_pkg::reg_idx_t rd;
        logic                 branch;
        logic                 jump;
        logic                 jump_reg;
        logic                 reg_wen;
        logic                 mem_ren;
        logic                 mem_wen;
        exu_op_pkg::csr_wen_t csr_wen;
    } result_t;

endpackage

// File: rtl/imm_former.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module imm_former (
    input  exu_op_pkg::word_t     raw,
    input  exu_op_pkg::imm_kind_e kind,
    output exu_op_pkg::word_t     imm
);

    always_comb begin
        case (kind)
            exu_op_pkg::imm_i12: begin
                imm = {{(`EXU_XLEN-12){raw[11]}}, raw[11:0]};
            end
            exu_op_pkg::imm_u20: begin
                imm = {raw[19:0], 12'd0};
            end
            exu_op_pkg::imm_j20: begin
                imm = {{(`EXU_XLEN-21){raw[19]}}, raw[19:0], 1'b0}; // halfword offset.
            end
            exu_op_pkg::imm_b12: begin
                imm = {{(`EXU_XLEN-13){raw[11]}}, raw[11:0], 1'b0};
            end
            exu_op_pkg::imm_u5: begin
                imm = {{(`EXU_XLEN-5){1'b0}}, raw[4:0]}; // zero extended.
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module alu (
    input  exu_op_pkg::word_t   a,
    input  exu_op_pkg::word_t   b,
    input  exu_op_pkg::alu_op_e op,
    input  logic                invert,
    output exu_op_pkg::word_t   y
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    exu_op_pkg::word_t       res;

    assign shamt = b[`EXU_SHAMT_W-1:0];

    always_comb begin
        case (op)
            exu_op_pkg::alu_add: begin
                res = a + b;
            end
            exu_op_pkg::alu_sub: begin
                res = a - b;
            end
            exu_op_pkg::alu_sll: begin
                res = a << shamt;
            end
            exu_op_pkg::alu_slt: begin
                res = exu_op_pkg::word_t'($signed(a) < $signed(b));
            end
            exu_op_pkg::alu_sltu: begin
                res = exu_op_pkg::word_t'(a < b);
            end
            exu_op_pkg::alu_xor: begin
                res = a ^ b;
            end
            exu_op_pkg::alu_srl: begin
                res = a >> shamt;
            end
            exu_op_pkg::alu_sra: begin
                res = exu_op_pkg::word_t'($signed(a) >>> shamt); // keeps the sign.
            end
            exu_op_pkg::alu_or: begin
                res = a | b;
            end
            exu_op_pkg::alu_and: begin
                res = a & b;
            end
            exu_op_pkg::alu_eq: begin
                res = exu_op_pkg::word_t'(a == b);
            end
            exu_op_pkg::alu_pass_b: begin
                res = b; // lui and csr moves.
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // compares only ever give 0 or 1, so flipping bit 0 negates them.
    assign y = res ^ exu_op_pkg::word_t'(invert);

endmodule

// File: rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  exu_bus_pkg::issue_t  issue,
    output logic                 result_valid,
    input  logic                 result_ready,
    output exu_bus_pkg::result_t result,
    input  logic                 redirect_taken
);

    exu_bus_pkg::issue_t held;
    logic                valid_q;
    logic                accept;
    logic                fire;
    logic                flush;
    exu_op_pkg::word_t   imm;
    exu_op_pkg::word_t   opa;
    exu_op_pkg::word_t   opb;
    exu_op_pkg::word_t   alu_y;

    assign issue_ready = result_ready || !valid_q;
    assign accept      = issue_valid && issue_ready;
    assign fire        = valid_q && result_ready;
    assign flush       = fire && redirect_taken; // wrong path behind a taken redirect.

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= !flush;
        end else if (fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held <= issue;
        end
    end

    imm_former u_imm_former (
        .raw  (held.imm),
        .kind (held.imm_kind),
        .imm  (imm)
    );

    always_comb begin
        case (held.opa_sel)
            exu_op_pkg::opa_rs1: opa = held.rs1;
            exu_op_pkg::opa_pc:  opa = held.pc;
            default:             opa = '0;
        endcase
    end

    always_comb begin
        case (held.opb_sel)
            exu_op_pkg::opb_imm: opb = imm;
            exu_op_pkg::opb_rs2: opb = held.rs2;
            exu_op_pkg::opb_csr: opb = held.csr;
            default:             opb = exu_op_pkg::word_t'(4);
        endcase
    end

    alu u_alu (
        .a      (opa),
        .b      (opb),
        .op     (held.alu_op),
        .invert (held.invert),
        .y      (alu_y)
    );

    always_comb begin
        result.pc       = held.pc;
        result.rs1      = held.rs1;
        result.rs2      = held.rs2;
        result.csr      = held.csr;
        result.imm      = imm;
        result.alu      = alu_y;
        result.funct3   = held.funct3;
        result.rd       = held.rd;
        result.branch   = held.branch;
        result.jump     = held.jump;
        result.jump_reg = held.jump_reg;
        result.reg_wen  = held.reg_wen;
        result.mem_ren  = held.mem_ren;
        result.mem_wen  = held.mem_wen;
        result.csr_wen  = held.csr_wen;
    end

    assign result_valid = valid_q;

    a_stall_hold: assert property (
        @(posedge clock) disable iff (reset)
        (result_valid && !result_ready) |=> (result_valid && $stable(result))
    ) else $error("result changed while stalled.");

    a_reset_idle: assert property (
        @(posedge clock) reset |=> !result_valid
    ) else $error("result_valid high right after reset.");

    // redirect comes back from the resolver behind this stage.
    a_flush_kill: assert property (
        @(posedge clock) disable iff (reset)
        (result_valid && result_ready && redirect_taken) |=> !result_valid
    ) else $error("killed instruction presented after redirect.");

endmodule

// File: rtl/branch_resolve.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module branch_resolve (
    input  logic                 result_valid,
    input  exu_bus_pkg::result_t result,
    output logic                 redirect_taken,
    output exu_op_pkg::word_t    redirect_target
);

    exu_op_pkg::word_t base;
    exu_op_pkg::word_t sum;
    logic              taken;

    // alu bit 0 holds the compare outcome for branches.
    assign taken = result.jump || (result.branch && result.alu[0]);

    assign redirect_taken = result_valid && taken;

    assign base = result.jump_reg ? result.rs1 : result.pc;
    assign sum  = base + result.imm;

    always_comb begin
        if (result.jump_reg) begin
            redirect_target = {sum[`EXU_XLEN-1:1], 1'b0}; // jalr clears bit 0.
        end else begin
            redirect_target = sum;
        end
    end

    // decode must never mark an instruction as both kinds.
    always_comb begin
        if (result_valid) begin
            a_one_kind: assert (!(result.branch && result.jump))
                else $error("branch and jump both set.");
        end
    end

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  exu_bus_pkg::issue_t  issue,
    output logic                 result_valid,
    input  logic                 result_ready,
    output exu_bus_pkg::result_t result,
    output logic                 redirect_taken,
    output exu_op_pkg::word_t    redirect_target
);

    exec_stage u_exec_stage (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue          (issue),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result         (result),
        .redirect_taken (redirect_taken) // flushes the wrong-path issue.
    );

    branch_resolve u_branch_resolve (
        .result_valid    (result_valid),
        .result          (result),
        .redirect_taken  (redirect_taken),
        .redirect_target (redirect_target)
    );

endmodule

// File: dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

    typedef exu_op_pkg::word_t    word_t;
    typedef exu_bus_pkg::issue_t  issue_t;
    typedef exu_bus_pkg::result_t result_t;

    typedef struct packed {
        word_t                pc;
        word_t                rs1;
        word_t                rs2;
        word_t                csr;
        word_t                imm;
        word_t                alu;
        word_t                target;
        exu_op_pkg::funct3_t  funct3;
        exu_op_pkg::reg_idx_t rd;
        logic [2:0]           kind; // branch, jump, jump_reg.
        logic [6:0]           ctrl; // reg_wen, mem_ren, mem_wen, csr_wen.
        logic                 taken;
    } expect_t;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int N_RANDOM      = 200;
    localparam int N_ROUNDS      = 8;
    localparam int OPS_PER_ROUND = 16;
    localparam int TOTAL_OPS     = 2 * N_RANDOM + N_ROUNDS * OPS_PER_ROUND;

    logic    clock;
    logic    reset;
    logic    issue_valid;
    logic    issue_ready;
    issue_t  issue;
    logic    result_valid;
    logic    result_ready;
    result_t result;
    logic    redirect_taken;
    word_t   redirect_target;

    logic    random_ready;
    logic    seen_issue;
    expect_t expected[$];
    int      checks;
    int      value_errors;
    int      other_errors;
    int      killed;

    exu_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .issue           (issue),
        .result_valid    (result_valid),
        .result_ready    (result_ready),
        .result          (result),
        .redirect_taken  (redirect_taken),
        .redirect_target (redirect_target)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic report_mismatch(string name, word_t exp, word_t got);
        value_errors++;
        $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, got);
    endtask

    task automatic report_failure(string what);
        other_errors++;
        $display("time %0t: %s", $time, what);
    endtask

    // shift into the top, then arithmetic shift back down.
    function automatic word_t expect_imm(word_t raw, exu_op_pkg::imm_kind_e kind);
        word_t v;
        case (kind)
            exu_op_pkg::imm_i12: v = $signed({raw[11:0], 20'd0}) >>> 20;
            exu_op_pkg::imm_u20: v = raw << 12;
            exu_op_pkg::imm_j20: v = $signed({raw[19:0], 12'd0}) >>> 11;
            exu_op_pkg::imm_b12: v = $signed({raw[11:0], 20'd0}) >>> 19;
            exu_op_pkg::imm_u5:  v = raw & 32'h0000_001f;
            default:             v = '0;
        endcase
        return v;
    endfunction

    function automatic word_t alu_model(word_t a, word_t b, exu_op_pkg::alu_op_e op);
        word_t y;
        case (op)
            exu_op_pkg::alu_add:    y = a + b;
            exu_op_pkg::alu_sub:    y = a - b;
            exu_op_pkg::alu_sll:    y = a << b[4:0];
            exu_op_pkg::alu_slt:    y = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            exu_op_pkg::alu_sltu:   y = {31'd0, a < b};
            exu_op_pkg::alu_xor:    y = a ^ b;
            exu_op_pkg::alu_srl:    y = a >> b[4:0];
            exu_op_pkg::alu_sra:    y = $signed(a) >>> b[4:0];
            exu_op_pkg::alu_or:     y = a | b;
            exu_op_pkg::alu_and:    y = a & b;
            exu_op_pkg::alu_eq:     y = {31'd0, a == b};
            exu_op_pkg::alu_pass_b: y = b;
            default:                y = '0;
        endcase
        return y;
    endfunction

    function automatic expect_t make_expect(issue_t item);
        expect_t e;
        word_t   a;
        word_t   b;
        e.pc     = item.pc;
        e.rs1    = item.rs1;
        e.rs2    = item.rs2;
        e.csr    = item.csr;
        e.funct3 = item.funct3;
        e.rd     = item.rd;
        e.kind   = {item.branch, item.jump, item.jump_reg};
        e.ctrl   = {item.reg_wen, item.mem_ren, item.mem_wen, item.csr_wen};
        e.imm    = expect_imm(item.imm, item.imm_kind);
        case (item.opa_sel)
            exu_op_pkg::opa_rs1: a = item.rs1;
            exu_op_pkg::opa_pc:  a = item.pc;
            default:             a = '0;
        endcase
        case (item.opb_sel)
            exu_op_pkg::opb_imm: b = e.imm;
            exu_op_pkg::opb_rs2: b = item.rs2;
            exu_op_pkg::opb_csr: b = item.csr;
            default:             b = 32'd4;
        endcase
        e.alu = alu_model(a, b, item.alu_op) ^ {31'd0, item.invert};
        if (item.jump) begin
            e.alu = item.pc + 32'd4; // link value.
        end
        e.taken = item.jump || (item.branch && e.alu[0]);
        if (item.jump_reg) begin
            e.target = (item.rs1 + e.imm) & 32'hffff_fffe;
        end else begin
            e.target = item.pc + e.imm;
        end
        return e;
    endfunction

    function automatic issue_t random_issue();
        issue_t item;
        word_t  r;
        item.pc  = $urandom() & 32'hffff_fffc;
        item.rs1 = $urandom();
        item.rs2 = $urandom();
        item.csr = $urandom();
        item.imm = $urandom();
        r = $urandom_range(0, 4);
        item.imm_kind = exu_op_pkg::imm_kind_e'(r[2:0]);
        r = $urandom_range(0, 11);
        item.alu_op = exu_op_pkg::alu_op_e'(r[3:0]);
        r = $urandom_range(0, 3);
        item.invert = (r == 0);
        r = $urandom_range(0, 2);
        item.opa_sel = exu_op_pkg::opa_sel_e'(r[1:0]);
        r = $urandom();
        item.opb_sel  = exu_op_pkg::opb_sel_e'(r[1:0]);
        item.branch   = 1'b0;
        item.jump     = 1'b0;
        item.jump_reg = 1'b0;
        item.funct3   = r[4:2];
        item.rd       = r[9:5];
        item.reg_wen  = r[10];
        item.mem_ren  = r[11];
        item.mem_wen  = r[12];
        item.csr_wen  = r[16:13];
        return item;
    endfunction

    function automatic exu_op_pkg::alu_op_e compare_op(int sel);
        case (sel)
            0:       return exu_op_pkg::alu_slt;
            1:       return exu_op_pkg::alu_sltu;
            default: return exu_op_pkg::alu_eq;
        endcase
    endfunction

    // holds the item until the stage takes it.
    task automatic send(issue_t item);
        issue_valid <= 1'b1;
        issue       <= item;
        @(posedge clock);
        while (!issue_ready) begin
            @(posedge clock);
        end
        issue_valid <= 1'b0;
    endtask

    task automatic send_branch(exu_op_pkg::alu_op_e op, logic inv, logic same);
        issue_t item;
        item = random_issue();
        if (same) begin
            item.rs2 = item.rs1;
        end
        item.alu_op   = op;
        item.invert   = inv;
        item.opa_sel  = exu_op_pkg::opa_rs1;
        item.opb_sel  = exu_op_pkg::opb_rs2;
        item.imm_kind = exu_op_pkg::imm_b12;
        item.branch   = 1'b1;
        send(item);
    endtask

    task automatic send_jump(logic via_reg);
        issue_t item;
        item = random_issue();
        item.alu_op   = exu_op_pkg::alu_add;
        item.invert   = 1'b0;
        item.opa_sel  = exu_op_pkg::opa_pc;
        item.opb_sel  = exu_op_pkg::opb_four;
        item.jump     = 1'b1;
        item.jump_reg = via_reg;
        if (via_reg) begin
            item.imm_kind = exu_op_pkg::imm_i12;
        end else begin
            item.imm_kind = exu_op_pkg::imm_j20;
        end
        send(item);
    endtask

    task automatic check_result(expect_t e);
        logic [2:0] kind;
        logic [6:0] ctrl;
        kind = {result.branch, result.jump, result.jump_reg};
        ctrl = {result.reg_wen, result.mem_ren, result.mem_wen, result.csr_wen};
        checks++;
        assert (result.pc == e.pc) else report_mismatch("result.pc", e.pc, result.pc);
        assert (result.rs1 == e.rs1) else report_mismatch("result.rs1", e.rs1, result.rs1);
        assert (result.rs2 == e.rs2) else report_mismatch("result.rs2", e.rs2, result.rs2);
        assert (result.csr == e.csr) else report_mismatch("result.csr", e.csr, result.csr);
        assert (result.rd == e.rd)
            else report_mismatch("result.rd", word_t'(e.rd), word_t'(result.rd));
        assert (result.funct3 == e.funct3)
            else report_mismatch("result.funct3", word_t'(e.funct3), word_t'(result.funct3));
        assert (kind == e.kind)
            else report_mismatch("result.branch_jump_jump_reg", word_t'(e.kind), word_t'(kind));
        assert (ctrl == e.ctrl)
            else report_mismatch("result.wen_ren_csr_wen", word_t'(e.ctrl), word_t'(ctrl));
        assert (result.imm == e.imm) else report_mismatch("result.imm", e.imm, result.imm);
        assert (result.alu == e.alu) else report_mismatch("result.alu", e.alu, result.alu);
        assert (redirect_taken == e.taken)
            else report_mismatch("redirect_taken", {31'd0, e.taken}, {31'd0, redirect_taken});
        if (e.taken) begin
            assert (redirect_target == e.target)
                else report_mismatch("redirect_target", e.target, redirect_target);
        end
    endtask

    always @(posedge clock) begin
        if (random_ready) begin
            result_ready <= ($urandom_range(0, 2) != 0);
        end else begin
            result_ready <= 1'b1;
        end
    end

    // pop the transferring result before pushing a new accept.
    always @(posedge clock) begin
        expect_t e;
        if (!reset) begin
            if (result_valid && result_ready) begin
                if (expected.size() == 0) begin
                    report_failure("a result transferred with no issue outstanding");
                end else begin
                    e = expected.pop_front();
                    check_result(e);
                end
            end
            if (issue_valid && issue_ready) begin
                seen_issue <= 1'b1;
                if (result_valid && result_ready && redirect_taken) begin
                    killed++; // wrong path, dropped from the model.
                end else begin
                    expected.push_back(make_expect(issue));
                end
            end
        end
    end

    a_latency: assert property (@(posedge clock) disable iff (reset)
        (issue_valid && issue_ready && !(result_valid && result_ready && redirect_taken))
        |=> result_valid)
        else report_failure("result_valid did not rise one cycle after an accepted issue");

    a_no_extra: assert property (@(posedge clock) disable iff (reset)
        (!(issue_valid && issue_ready) && !(result_valid && !result_ready)) |=> !result_valid)
        else report_failure("result_valid high without an accepted issue");

    a_ready: assert property (@(posedge clock) disable iff (reset) result_ready |-> issue_ready)
        else report_failure("issue_ready low while result_ready was high");

    a_hold: assert property (@(posedge clock) disable iff (reset)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)))
        else report_failure("result changed while back-pressured");

    a_flush: assert property (@(posedge clock) disable iff (reset)
        (result_valid && result_ready && redirect_taken) |=> !result_valid)
        else report_failure("the issue behind a taken redirect reached the result port");

    a_not_taken: assert property (@(posedge clock) disable iff (reset)
        (result_valid && result.branch && !result.alu[0]) |-> !redirect_taken)
        else report_failure("redirect taken on a branch that compared false");

    a_after_reset: assert property (@(posedge clock)
        (!reset && !seen_issue) |-> (!result_valid && !redirect_taken && issue_ready))
        else report_failure("stage not idle after reset before the first issue");

    initial begin : watchdog
        #((TOTAL_OPS * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all operations completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        logic same;
        void'($urandom(57));
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue        = '0;
        result_ready = 1'b1;
        random_ready = 1'b0;
        seen_issue   = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        killed       = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        for (int i = 0; i < N_RANDOM; i++) begin
            send(random_issue());
            if ($urandom_range(0, 7) == 0) begin
                @(posedge clock); // idle gap.
            end
        end

        random_ready <= 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            send(random_issue());
        end

        // ready held high so each filler lands on the redirect edge.
        random_ready <= 1'b0;
        for (int round = 0; round < N_ROUNDS; round++) begin
            same = (round % 2 == 0);
            for (int k = 0; k < 6; k++) begin
                send_branch(compare_op(k / 2), (k % 2 == 1), same);
                send(random_issue());
            end
            send_jump(1'b0);
            send(random_issue());
            send_jump(1'b1);
            send(random_issue());
        end

        while (expected.size() != 0) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        if (checks == 0) begin
            report_failure("no result was ever checked");
        end
        $display("checks %0d, value errors %0d, other errors %0d, killed issues %0d",
                 checks, value_errors, other_errors, killed);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/exu_op_pkg.sv
rtl/exu_bus_pkg.sv
rtl/imm_former.sv
rtl/alu.sv
rtl/exec_stage.sv
rtl/branch_resolve.sv
rtl/exu_top.sv
dv/exu_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench.
# Any variable below can be overridden, e.g. make LOG=run1.log

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LFLAGS    ?= --lint-only --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, whatever the simulator returns.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
